// ==== cavlc_params.svh ====
`default_nettype none

`ifndef CAVLC_PARAMS_SVH
`define CAVLC_PARAMS_SVH

`define COEF_W          15  // signed coefficient width.
`define NUM_COEF        16
`define IDX_W           4
`define SFX_LEN_W       3   // suffix length runs from 0 up to 6.
`define CODE_W          28  // marker bit plus at most 12 suffix bits, prefix zeros implied.
`define LEN_W           5
`define LVL_FIFO_DEPTH  4

`endif

`default_nettype wire

// ==== cavlc_pkg.sv ====
`include "cavlc_params.svh"
`default_nettype none

package cavlc_pkg;

    typedef logic signed [`COEF_W-1:0] coef_t;

    typedef coef_t [`NUM_COEF-1:0] coef_blk_t;  // index 0 is scan position 0.

    typedef logic [`CODE_W-1:0] code_t;  // right aligned, prefix zeros given by the length.

    typedef logic [`LEN_W-1:0] len_t;

    typedef struct packed {
        coef_t level;
        logic  first;      // first coded level of the block.
        logic  first_adj;  // level code is lowered by two on this item.
        logic  sfx_init;   // suffix length start, only valid with first.
        logic  last;
        logic  empty;      // block carries no level at all.
    } level_item_t;

    typedef enum logic {
        SCAN_IDLE,
        SCAN_EMIT
    } scan_state_t;

endpackage

`default_nettype wire

// ==== level_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface level_if
    import cavlc_pkg::*;
();

    logic        valid;
    logic        ready;
    level_item_t item;

    // Item is held stable while valid waits for ready.
    modport producer (
        output valid,
        output item,
        input  ready
    );

    modport consumer (
        input  valid,
        input  item,
        output ready
    );

endinterface

`default_nettype wire

// ==== level_scanner.sv ====
`include "cavlc_params.svh"
`timescale 1ns/1ps
`default_nettype none

module level_scanner
    import cavlc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  coef_blk_t coef,
    level_if.producer lvl
);

    scan_state_t          state;

    logic [`NUM_COEF-1:0] nz_mask;
    logic [`NUM_COEF-1:0] t1_mask;
    logic [`NUM_COEF-1:0] lvl_mask;
    logic [`IDX_W:0]      total;
    logic [1:0]           t1_cnt;
    logic                 t1_run;
    coef_t                cur;

    coef_blk_t            blk_q;
    logic [`NUM_COEF-1:0] mask_q;
    logic                 first_q;
    logic                 empty_q;
    logic                 adj_q;
    logic                 sfx_q;

    logic [`IDX_W-1:0]    top_idx;
    logic                 one_left;
    logic                 last_item;
    logic                 accept;
    logic                 xfer;
    level_item_t          item_d;

    assign in_ready = (state == SCAN_IDLE);
    assign accept   = in_valid && in_ready;
    assign xfer     = lvl.valid && lvl.ready;

    // Walk down from the high end; zeros are skipped and do not end the run of ones.
    always_comb
    begin
        nz_mask = '0;
        t1_mask = '0;
        total   = '0;
        t1_cnt  = '0;
        t1_run  = 1'b1;
        cur     = '0;
        for (int i = `NUM_COEF - 1; i >= 0; i--)
        begin
            cur = coef[i];
            if (cur != '0)
            begin
                nz_mask[i] = 1'b1;
                total      = total + 1'b1;
                if (t1_run && (cur == coef_t'(1) || cur == '1))
                begin
                    t1_mask[i] = 1'b1;
                    t1_cnt     = t1_cnt + 1'b1;
                    t1_run     = (t1_cnt != 2'd3);  // at most three trailing ones.
                end
                else
                begin
                    t1_run = 1'b0;
                end
            end
        end
    end

    assign lvl_mask = nz_mask & ~t1_mask;

    always_comb
    begin
        top_idx = '0;
        for (int i = 0; i < `NUM_COEF; i++)
        begin
            if (mask_q[i])
            begin
                top_idx = i[`IDX_W-1:0];
            end
        end
    end

    assign one_left  = ((mask_q & (mask_q - 1'b1)) == '0);
    assign last_item = empty_q || one_left;

    always_comb
    begin
        item_d.level     = empty_q ? '0 : blk_q[top_idx];
        item_d.first     = first_q;
        item_d.first_adj = first_q && adj_q;
        item_d.sfx_init  = sfx_q;
        item_d.last      = last_item;
        item_d.empty     = empty_q;
    end

    assign lvl.valid = (state == SCAN_EMIT);
    assign lvl.item  = item_d;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= SCAN_IDLE;
            mask_q  <= '0;
            first_q <= 1'b0;
            empty_q <= 1'b0;
        end
        else if (accept)
        begin
            state   <= SCAN_EMIT;
            mask_q  <= lvl_mask;
            first_q <= 1'b1;
            empty_q <= (lvl_mask == '0);  // a lone empty item closes the block.
        end
        else if (xfer)
        begin
            mask_q[top_idx] <= 1'b0;
            first_q         <= 1'b0;
            if (last_item)
            begin
                state <= SCAN_IDLE;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            blk_q <= coef;
            adj_q <= (t1_cnt != 2'd3);
            sfx_q <= (total > 'd10) && (t1_cnt != 2'd3);
        end
    end

endmodule

`default_nettype wire

// ==== level_fifo.sv ====
`include "cavlc_params.svh"
`timescale 1ns/1ps
`default_nettype none

module level_fifo
    import cavlc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    level_if.consumer wr,
    level_if.producer rd
);

    localparam int DEPTH = `LVL_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    level_item_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign wr.ready = (count != DEPTH[PTR_W:0]);
    assign rd.valid = (count != '0);
    assign rd.item  = mem[rd_ptr];  // head entry feeds the coder directly.

    assign wr_en = wr.valid && wr.ready;
    assign rd_en = rd.valid && rd.ready;

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= wr.item;
        end
    end

    // Depth is a power of two, so the pointers wrap on their own.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== level_vlc_coder.sv ====
`include "cavlc_params.svh"
`timescale 1ns/1ps
`default_nettype none

module level_vlc_coder
    import cavlc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    level_if.consumer lvl,
    output logic      out_valid,
    input  logic      out_ready,
    output code_t     out_code,
    output len_t      out_len,
    output logic      out_last
);

    localparam logic [`SFX_LEN_W-1:0] SFX_ONE   = 1;
    localparam logic [`SFX_LEN_W-1:0] SFX_MAX   = 6;
    localparam logic [`COEF_W:0]      ESC_SHORT = 14;
    localparam logic [`COEF_W:0]      ESC_LONG  = 30;

    logic [`SFX_LEN_W-1:0] sfx_q;
    logic [`SFX_LEN_W-1:0] sfx_cur;
    logic [`SFX_LEN_W-1:0] sfx_bump;
    logic [`SFX_LEN_W-1:0] sfx_next;
    logic                  neg;
    logic [`COEF_W-1:0]    mag;
    logic [`COEF_W-1:0]    thr;
    logic [`COEF_W:0]      lvl_code;
    logic [`COEF_W:0]      esc_base;
    logic [`COEF_W:0]      tmp;
    logic [3:0]            prefix;
    logic [3:0]            sfx_size;
    logic [11:0]           suffix;
    code_t                 code_d;
    len_t                  len_d;
    logic                  take;

    assign lvl.ready = !out_valid || out_ready;  // output register free or draining now.
    assign take      = lvl.valid && lvl.ready;

    assign sfx_cur = lvl.item.first ? {{(`SFX_LEN_W-1){1'b0}}, lvl.item.sfx_init} : sfx_q;
    assign neg     = lvl.item.level[`COEF_W-1];
    assign mag     = neg ? -lvl.item.level : lvl.item.level;

    // 2*mag - 2 for positive levels, 2*mag - 1 for negative ones.
    assign lvl_code = {mag, 1'b0}
                    - {{(`COEF_W-1){1'b0}}, !neg, neg}
                    - {{(`COEF_W-1){1'b0}}, lvl.item.first_adj, 1'b0};

    assign esc_base = {{(`COEF_W-3){1'b0}}, 4'd15} << sfx_cur;

    always_comb
    begin
        prefix   = '0;
        sfx_size = '0;
        suffix   = '0;
        tmp      = '0;
        if (sfx_cur == '0)
        begin
            if (lvl_code < ESC_SHORT)
            begin
                prefix = lvl_code[3:0];
            end
            else if (lvl_code < ESC_LONG)
            begin
                prefix   = 4'd14;
                sfx_size = 4'd4;
                tmp      = lvl_code - ESC_SHORT;
                suffix   = tmp[11:0];
            end
            else
            begin
                prefix   = 4'd15;
                sfx_size = 4'd12;
                tmp      = lvl_code - ESC_LONG;
                suffix   = tmp[11:0];
            end
        end
        else if (lvl_code < esc_base)
        begin
            tmp      = lvl_code >> sfx_cur;
            prefix   = tmp[3:0];
            sfx_size = {1'b0, sfx_cur};
            tmp      = lvl_code & ~({(`COEF_W+1){1'b1}} << sfx_cur);
            suffix   = tmp[11:0];
        end
        else
        begin
            prefix   = 4'd15;  // escape with a fixed 12 bit suffix.
            sfx_size = 4'd12;
            tmp      = lvl_code - esc_base;
            suffix   = tmp[11:0];
        end
        code_d = (code_t'(1) << sfx_size) | code_t'(suffix);
        len_d  = len_t'(prefix) + len_t'(sfx_size) + len_t'(1);
    end

    // Suffix length steps up once the magnitude passes 3 << (length - 1).
    assign sfx_bump = (sfx_cur == '0) ? SFX_ONE : sfx_cur;
    assign thr      = {{(`COEF_W-2){1'b0}}, 2'd3} << (sfx_bump - SFX_ONE);
    assign sfx_next = ((mag > thr) && (sfx_bump < SFX_MAX)) ? sfx_bump + SFX_ONE : sfx_bump;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            sfx_q     <= '0;
        end
        else if (take)
        begin
            out_valid <= 1'b1;
            if (!lvl.item.empty)
            begin
                sfx_q <= sfx_next;
            end
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            out_code <= lvl.item.empty ? '0 : code_d;
            out_len  <= lvl.item.empty ? '0 : len_d;  // empty block gives a zero length word.
            out_last <= lvl.item.last;
        end
    end

endmodule

`default_nettype wire

// ==== cavlc_level_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cavlc_level_top
    import cavlc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    output logic      in_ready,
    input  coef_blk_t coef,
    output logic      out_valid,
    input  logic      out_ready,
    output code_t     out_code,
    output len_t      out_len,
    output logic      out_last
);

    level_if scan_lvl ();
    level_if fifo_lvl ();  // buffered levels in reverse scan order.

    level_scanner u_scanner (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .coef     (coef),
        .lvl      (scan_lvl.producer)
    );

    level_fifo u_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (scan_lvl.consumer),
        .rd  (fifo_lvl.producer)
    );

    level_vlc_coder u_coder (
        .clk       (clk),
        .rst       (rst),
        .lvl       (fifo_lvl.consumer),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_code  (out_code),
        .out_len   (out_len),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

// ==== cavlc_level_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module cavlc_level_assert
    import cavlc_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  in_ready,
    input logic  out_valid,
    input logic  out_ready,
    input code_t out_code,
    input len_t  out_len,
    input logic  out_last
);

    int unsigned fail_count = 0;

    // a stalled codeword holds until the sink takes it.
    property hold_while_stalled;
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_code) && $stable(out_len) && $stable(out_last));
    endproperty

    a_hold: assert property (hold_while_stalled)
        else
        begin
            fail_count++;
            $error("output codeword changed while stalled");
        end

    a_len: assert property (@(posedge clk) disable iff (rst) out_valid |-> (out_len <= 5'd28))
        else
        begin
            fail_count++;
            $error("codeword length above 28");
        end

    a_ready: assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else
        begin
            fail_count++;
            $error("in_ready low in the first cycle after reset");
        end

endmodule

`default_nettype wire

// ==== tb_cavlc_level.sv ====
`include "cavlc_params.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_cavlc_level
    import cavlc_pkg::*;
();

    typedef struct packed {
        coef_blk_t blk;
        int        n_codes;
        int        n_bits;
        logic      has_first;
        code_t     first_code;
        len_t      first_len;
    } row_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    coef_blk_t coef;
    logic      out_valid;
    logic      out_ready = 1'b0;
    code_t     out_code;
    len_t      out_len;
    logic      out_last;

    row_t rows[$];
    int   exp_code[$];
    int   exp_len[$];
    bit   exp_last[$];
    int   blocks_done = 0;
    int   codes_in_blk = 0;
    int   bits_in_blk = 0;
    int   cycle_count = 0;
    int   cycle_limit = 1000;

    cavlc_level_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .coef      (coef),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_code  (out_code),
        .out_len   (out_len),
        .out_last  (out_last)
    );

    bind cavlc_level_top cavlc_level_assert u_assert (
        .clk       (clk),
        .rst       (rst),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_code  (out_code),
        .out_len   (out_len),
        .out_last  (out_last)
    );

    always #10 clk = ~clk;

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // software model of the level coder, one expected codeword per level.
    task automatic predict_block(input coef_blk_t blk, output int n_codes, output int n_bits);
        int levels[$];
        int total;
        int t1;
        bit run;
        int v;
        int sfx;
        int mag;
        int lcode;
        int prefix;
        int ssize;
        int suf;
        total = 0;
        t1 = 0;
        run = 1'b1;
        n_codes = 0;
        n_bits = 0;
        for (int i = `NUM_COEF - 1; i >= 0; i--)
        begin
            v = $signed(blk[i]);
            if (v != 0)
            begin
                total++;
                if (run && t1 < 3 && (v == 1 || v == -1))
                    t1++;
                else
                begin
                    run = 1'b0;
                    levels.push_back(v);  // levels gathered from the high end down.
                end
            end
        end
        if (levels.size() == 0)
        begin
            exp_code.push_back(0);
            exp_len.push_back(0);
            exp_last.push_back(1'b1);
            n_codes = 1;
        end
        else
        begin
            sfx = (total > 10 && t1 < 3) ? 1 : 0;
            for (int k = 0; k < levels.size(); k++)
            begin
                v = levels[k];
                mag = (v < 0) ? -v : v;
                lcode = (v > 0) ? 2 * v - 2 : -2 * v - 1;
                if (k == 0 && t1 < 3)
                    lcode = lcode - 2;
                prefix = 15;
                ssize = 12;
                if (sfx == 0)
                begin
                    if (lcode < 14)
                    begin
                        prefix = lcode;
                        ssize = 0;
                        suf = 0;
                    end
                    else if (lcode < 30)
                    begin
                        prefix = 14;
                        ssize = 4;
                        suf = lcode - 14;
                    end
                    else
                        suf = lcode - 30;
                end
                else if (lcode < (15 << sfx))
                begin
                    prefix = lcode >> sfx;
                    ssize = sfx;
                    suf = lcode - (prefix << sfx);
                end
                else
                    suf = lcode - (15 << sfx);
                exp_code.push_back((1 << ssize) | suf);
                exp_len.push_back(prefix + 1 + ssize);
                exp_last.push_back(k == levels.size() - 1);
                n_codes++;
                n_bits += prefix + 1 + ssize;
                if (sfx == 0)
                    sfx = 1;
                if (mag > (3 << (sfx - 1)) && sfx < 6)
                    sfx++;
            end
        end
    endtask

    task automatic add_hand_row(input coef_blk_t blk, input int n_codes, input int n_bits,
                                input code_t first_code, input len_t first_len);
        row_t row;
        int   model_n;
        int   model_bits;
        predict_block(blk, model_n, model_bits);
        check_value("model codeword count", model_n, n_codes);
        check_value("model code bit total", model_bits, n_bits);
        row = '{blk, n_codes, n_bits, 1'b1, first_code, first_len};
        rows.push_back(row);
    endtask

    task automatic add_random_row();
        row_t      row;
        coef_blk_t blk;
        int        kind;
        int        mag;
        int        model_n;
        int        model_bits;
        blk = '0;
        for (int i = 0; i < `NUM_COEF; i++)
        begin
            kind = $urandom_range(0, 7);
            if (kind < 3)
                mag = 0;
            else if (kind < 5)
                mag = 1;
            else if (kind < 7)
                mag = $urandom_range(2, 15);
            else
                mag = $urandom_range(16, 2000);
            blk[i] = ($urandom_range(0, 1) == 1) ? coef_t'(-mag) : coef_t'(mag);
        end
        predict_block(blk, model_n, model_bits);
        row = '{blk, model_n, model_bits, 1'b0, '0, '0};
        rows.push_back(row);
    endtask

    task automatic build_table();
        coef_blk_t blk;
        blk = '0;
        add_hand_row(blk, 1, 0, 28'h0, 5'd0);
        blk[0] = 15'sd1;
        blk[3] = -15'sd1;
        blk[5] = 15'sd1;
        add_hand_row(blk, 1, 0, 28'h0, 5'd0);  // three trailing ones leave nothing to code.
        blk = '0;
        blk[0] = 15'sd2;
        blk[1] = -15'sd3;
        blk[2] = 15'sd1;
        add_hand_row(blk, 2, 7, 28'h1, 5'd4);
        blk = '0;
        blk[0] = 15'sd9;
        add_hand_row(blk, 1, 19, 28'h10, 5'd19);
        blk[0] = -15'sd20;
        add_hand_row(blk, 1, 28, 28'h1007, 5'd28);
        blk = '0;
        for (int i = 0; i <= 10; i++)
            blk[i] = 15'sd100;
        add_hand_row(blk, 11, 173, 28'h10a6, 5'd28);  // starts at suffix length 1.
        for (int i = 0; i < 8; i++)
            blk[i] = 15'sd5;
        blk[8] = 15'sd1;
        blk[9] = -15'sd1;
        blk[10] = 15'sd1;
        add_hand_row(blk, 8, 44, 28'h1, 5'd9);
        blk = '0;
        blk[2] = -15'sd1;
        blk[4] = 15'sd1;
        blk[6] = 15'sd1;
        blk[9] = -15'sd1;
        add_hand_row(blk, 1, 2, 28'h1, 5'd2);  // fourth one is coded as a level.
        for (int n = 0; n < 40; n++)
            add_random_row();
    endtask

    always @(posedge clk)
    begin
        if (rst)
            out_ready <= 1'b0;
        else
            out_ready <= ($urandom_range(0, 3) != 0);
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: blocks did not finish within %0d cycles", cycle_limit);
            stop_on_failure();
        end
    end

    always @(posedge clk)
    begin
        if (u_dut.u_assert.fail_count != 0)
        begin
            $display("a bound assertion on the DUT handshake failed");
            stop_on_failure();
        end
    end

    always @(posedge clk)
    begin : collect
        row_t row;
        if (!rst && out_valid && out_ready)
        begin
            if (exp_code.size() == 0)
            begin
                $display("codeword seen on the output when none was expected");
                stop_on_failure();
            end
            row = rows[blocks_done];
            if (row.has_first && codes_in_blk == 0)
            begin
                check_value("out_code first", out_code, row.first_code);
                check_value("out_len first", out_len, row.first_len);
            end
            check_value("out_code", out_code, exp_code.pop_front());
            check_value("out_len", out_len, exp_len.pop_front());
            check_value("out_last", out_last, exp_last.pop_front());
            codes_in_blk++;
            bits_in_blk += out_len;
            if (out_last)
            begin
                check_value("codeword count", codes_in_blk, row.n_codes);
                check_value("code bit total", bits_in_blk, row.n_bits);
                codes_in_blk = 0;
                bits_in_blk = 0;
                blocks_done++;
            end
        end
    end

    initial
    begin
        void'($urandom(32'h94b3));
        rst <= 1'b1;
        in_valid <= 1'b0;
        coef <= '0;
        build_table();
        cycle_limit = 200 * rows.size() + 100;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("in_ready", in_ready, 1);
        check_value("out_valid", out_valid, 0);
        for (int r = 0; r < rows.size(); r++)
        begin
            in_valid <= 1'b1;
            coef <= rows[r].blk;
            @(posedge clk);
            while (!in_ready)
                @(posedge clk);
        end
        in_valid <= 1'b0;
        coef <= '0;
        while (blocks_done < rows.size())
            @(posedge clk);
        repeat (5) @(posedge clk);
        if (exp_code.size() != 0 || out_valid)
        begin
            $display("output stream ended with codewords still outstanding");
            stop_on_failure();
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
cavlc_pkg.sv
level_if.sv
level_scanner.sv
level_fifo.sv
level_vlc_coder.sv
cavlc_level_top.sv
cavlc_level_assert.sv
tb_cavlc_level.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cavlc_level
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) cavlc_params.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)
